/* dv/imul_tests.svh */
/* directed tests, included inside imul_tb; they use its tasks and
   the shared expected-value queue */

task automatic verify_reset();
  int  cycles;
  logic seen;
  cycles = 0;
  seen = 1'b0;
  @(negedge clk);
  check_val(product_t'(resp_val), '0, "resp_val after reset");
  while (!seen && cycles < 5) begin
    seen = req_rdy;
    @(negedge clk);
    cycles++;
  end
  check_val(product_t'(seen), 64'd1, "req_rdy after reset");
  $display("reset: done, %0d failures so far", fail_cnt);
endtask

// magnitude edge cases and every sign combination
task automatic multiply_corners();
  operand_t ca[8] = '{32'h0, 32'h1, 32'hffffffff, 32'h7fffffff,
                      32'h80000000, 32'h80000000, 32'h80000000, 32'hffffffff};
  operand_t cb[8] = '{32'h12345678, 32'hffffffff, 32'hffffffff, 32'h7fffffff,
                      32'h1, 32'hffffffff, 32'h80000000, 32'h7fffffff};
  for (int i = 0; i < 8; i++) begin
    issue_req(ca[i], cb[i]);
    recv_resp($sformatf("corner pair %0d", i));
  end
  $display("corner operands: done, %0d failures so far", fail_cnt);
endtask

task automatic multiply_random();
  for (int i = 0; i < 200; i++) begin
    issue_req($urandom, $urandom);
    recv_resp($sformatf("random pair %0d", i));
  end
  $display("random operands: done, %0d failures so far", fail_cnt);
endtask

// sign stage, iteration stage and operand stage each hold one item
task automatic stall_and_drain();
  int       taken;
  bit       ok;
  bit       extra;
  operand_t a;
  operand_t b;
  taken = 0;
  ok = 1'b1;
  @(posedge clk);
  resp_rdy <= 1'b0;
  while (ok && taken < 8) begin
    a = $urandom;
    b = $urandom;
    send_req(a, b, WAIT_CYCLES, ok);
    if (ok) begin
      exp_q.push_back(signed_product(a, b));
      taken++;
    end
  end
  check_val(product_t'(taken), 64'd3, "requests accepted while stalled");
  @(posedge clk);
  resp_rdy <= 1'b1;
  for (int i = 0; i < taken; i++) begin
    recv_resp("response after stall");
  end
  // nothing beyond the accepted requests may come out
  extra = 1'b0;
  repeat (40) begin
    @(negedge clk);
    if (resp_val) begin
      extra = 1'b1;
    end
  end
  check_val(product_t'(extra), '0, "extra response after stall");
  $display("back-pressure: done, %0d failures so far", fail_cnt);
endtask

// feeder and a randomly stalling receiver run at the same time
task automatic stream_with_stalls();
  int depth_max;
  depth_max = 0;
  fork
    begin
      for (int i = 0; i < 20; i++) begin
        issue_req($urandom, $urandom);
      end
    end
    begin
      int got_cnt;
      int cycles;
      got_cnt = 0;
      cycles = 0;
      while (got_cnt < 20 && cycles < 20 * WAIT_CYCLES) begin
        @(posedge clk);
        resp_rdy <= (($urandom % 2) == 0);
        @(negedge clk);
        if (exp_q.size() > depth_max) begin
          depth_max = exp_q.size();
        end
        if (resp_val && resp_rdy) begin
          check_val(resp_result, exp_q.pop_front(), "streamed response");
          got_cnt++;
        end
        cycles++;
      end
      if (got_cnt < 20) begin
        report_timeout("streamed responses");
      end
    end
  join
  @(posedge clk);
  resp_rdy <= 1'b1;
  // more than one item waiting at once means the stages overlap
  check_val(product_t'(depth_max >= 2), 64'd1, "items in flight");
  $display("streaming: done, %0d failures so far", fail_cnt);
endtask

/* dv/imul_tb.sv */
/* testbench for the signed multiplier; tests come from imul_tests.svh
   and every wait is bounded by its own cycle limit */
`timescale 1ns/1ns
`default_nettype none

module imul_tb;
  import imul_pkg::*;

  localparam int WAIT_CYCLES = 100;

  logic     clk = 1'b0;
  logic     reset;
  logic     req_val;
  logic     req_rdy;
  operand_t req_a;
  operand_t req_b;
  logic     resp_val;
  logic     resp_rdy;
  product_t resp_result;

  int pass_cnt;
  int fail_cnt;
  // expected products in request order
  product_t exp_q[$];

  imul_top i_imul_top (
    .clk(clk), .reset(reset), .req_val(req_val), .req_rdy(req_rdy),
    .req_a(req_a), .req_b(req_b), .resp_val(resp_val), .resp_rdy(resp_rdy),
    .resp_result(resp_result)
  );

  always #5 clk = ~clk;

  // reference product from both operands sign-extended to 64 bits
  function automatic product_t signed_product(operand_t a, operand_t b);
    longint sa;
    longint sb;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    return sa * sb;
  endfunction

  task automatic check_val(input product_t got, input product_t exp, input string msg);
    if (got !== exp) begin
      $display("Fail at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t waiting for %s", $time, what);
    fail_cnt++;
  endtask

  // rdy is sampled at the negedge and the transfer lands on the next rising edge
  task automatic send_req(input operand_t a, input operand_t b, input int max_cycles,
                          output bit accepted);
    int cycles;
    accepted = 1'b0;
    cycles = 0;
    @(posedge clk);
    req_val <= 1'b1;
    req_a   <= a;
    req_b   <= b;
    while (!accepted && cycles < max_cycles) begin
      @(negedge clk);
      accepted = req_rdy;
      cycles++;
    end
    @(posedge clk);
    req_val <= 1'b0;
  endtask

  task automatic issue_req(input operand_t a, input operand_t b);
    bit ok;
    send_req(a, b, WAIT_CYCLES, ok);
    if (ok) begin
      exp_q.push_back(signed_product(a, b));
    end else begin
      report_timeout("request handshake");
    end
  endtask

  // takes one response and compares it with the oldest expected value
  task automatic recv_resp(input string msg);
    int cycles;
    bit got;
    cycles = 0;
    got = 1'b0;
    while (!got && cycles < WAIT_CYCLES) begin
      @(negedge clk);
      got = resp_val && resp_rdy;
      cycles++;
    end
    if (!got) begin
      report_timeout("a response");
    end else if (exp_q.size() == 0) begin
      $display("Response at %0t arrived with no request pending", $time);
      fail_cnt++;
    end else begin
      check_val(resp_result, exp_q.pop_front(), msg);
    end
    @(posedge clk);
  endtask

  `include "imul_tests.svh"

  initial begin
    void'($urandom(32'h3716b5cc));
    pass_cnt = 0;
    fail_cnt = 0;
    reset    <= 1'b1;
    req_val  <= 1'b0;
    req_a    <= '0;
    req_b    <= '0;
    resp_rdy <= 1'b1;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    verify_reset();
    multiply_corners();
    multiply_random();
    stall_and_drain();
    stream_with_stalls();
    $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+verilog
+incdir+dv
verilog/imul_pkg.sv
verilog/imul_if.sv
verilog/imul_operand_stage.sv
verilog/imul_iter_stage.sv
verilog/imul_sign_stage.sv
verilog/imul_top.sv
dv/imul_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the multiplier testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module imul_tb \
  --Mdir obj_dir -o imul_sim > build.log 2>&1 \
  && ./obj_dir/imul_sim > sim.log 2>&1 \
  && grep -qx "Test passed" sim.log \
  && echo "simulation ok" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* verilog/imul_config.svh */
/* widths for the signed multiplier; the counter must hold IMUL_WIDTH-1
   and the product width must be twice the operand width */
`ifndef IMUL_CONFIG_SVH
`define IMUL_CONFIG_SVH

// operand word width
`define IMUL_WIDTH 32

// full product width
`define IMUL_PROD_WIDTH 64

// iteration counter, counts IMUL_WIDTH steps down to zero
`define IMUL_CNT_WIDTH 5

`endif

/* verilog/imul_if.sv */
/* stage-to-stage val/rdy links; a transfer needs val and rdy high on
   one edge, and the sender holds val and its data until then */
`timescale 1ns/1ns
`default_nettype none

// operand stage to iteration stage
interface imul_mag_if;
  import imul_pkg::*;

  logic     val;
  logic     rdy;
  // unsigned magnitudes of both operands
  operand_t mag_a;
  operand_t mag_b;
  // product must be negated at the end
  logic     neg;

  modport src (output val, output mag_a, output mag_b, output neg, input rdy);
  modport dst (input val, input mag_a, input mag_b, input neg, output rdy);

endinterface

// iteration stage to sign stage
interface imul_prod_if;
  import imul_pkg::*;

  logic     val;
  logic     rdy;
  // unsigned product magnitude
  product_t mag;
  // sign carried along from the operand stage
  logic     neg;

  modport src (output val, output mag, output neg, input rdy);
  modport dst (input val, input mag, input neg, output rdy);

endinterface

`default_nettype wire

/* verilog/imul_iter_stage.sv */
/* second stage: shift-and-add on unsigned magnitudes, one partial product
   per cycle; busy for IMUL_WIDTH cycles and holds one transaction only */
`timescale 1ns/1ns
`default_nettype none

`include "imul_config.svh"

module imul_iter_stage (
  input  logic     clk,
  input  logic     reset,
  imul_mag_if.dst  mag,
  imul_prod_if.src prod
);
  import imul_pkg::*;

  // fsm encoding, 2'd3 unused
  localparam logic [1:0] IDLE = 2'd0;
  localparam logic [1:0] CALC = 2'd1;
  localparam logic [1:0] DONE = 2'd2;

  localparam logic [`IMUL_CNT_WIDTH-1:0] CNT_ONE = 1;

  logic [1:0] state;
  logic [1:0] state_next;

  // control to datapath
  logic load_en;
  logic shift_en;
  logic acc_en;

  // datapath to control
  logic cnt_is_zero;
  logic mplier_lsb;

  // datapath registers
  product_t                   mcand_q;
  operand_t                   mplier_q;
  product_t                   acc_q;
  logic [`IMUL_CNT_WIDTH-1:0] cnt_q;
  logic                       neg_q;

  // --------------------------------------------------
  // datapath
  // --------------------------------------------------

  // multiplicand widened to product width, moves left each step
  // multiplier moves right so bit 0 selects the next add
  always_ff @(posedge clk) begin
    if (load_en) begin
      mcand_q  <= {{(`IMUL_PROD_WIDTH-`IMUL_WIDTH){1'b0}}, mag.mag_a};
      mplier_q <= mag.mag_b;
      neg_q    <= mag.neg;
    end else if (shift_en) begin
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // accumulator cleared on load, adds shifted multiplicand when lsb set
  always_ff @(posedge clk) begin
    if (load_en) begin
      acc_q <= '0;
    end else if (acc_en) begin
      acc_q <= acc_q + mcand_q;
    end
  end

  // step counter, loaded with all ones = IMUL_WIDTH-1
  // stops at zero so it reads zero while waiting in DONE
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (load_en) begin
      cnt_q <= '1;
    end else if (shift_en && !cnt_is_zero) begin
      cnt_q <= cnt_q - CNT_ONE;
    end
  end

  assign cnt_is_zero = (cnt_q == '0);
  assign mplier_lsb  = mplier_q[0];

  // result goes out as magnitude, sign travels alongside
  assign prod.mag = acc_q;
  assign prod.neg = neg_q;

  // --------------------------------------------------
  // control
  // --------------------------------------------------

  // handshake, one transaction at a time
  assign mag.rdy  = (state == IDLE);
  assign prod.val = (state == DONE);

  // datapath enables
  assign load_en  = mag.val && mag.rdy;
  assign shift_en = (state == CALC);
  assign acc_en   = shift_en && mplier_lsb;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        // operands taken, start the iterations
        if (load_en) begin
          state_next = CALC;
        end
      end
      CALC: begin
        // last partial product goes in this cycle
        if (cnt_is_zero) begin
          state_next = DONE;
        end
      end
      DONE: begin
        // wait for the sign stage
        if (prod.rdy) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state != 2'd3);

  // all IMUL_WIDTH steps ran before the result shows up
  a_cnt_done: assert property (@(posedge clk) disable iff (reset)
    $rose(prod.val) |-> cnt_is_zero && $past(state == CALC));

endmodule

`default_nettype wire

/* verilog/imul_operand_stage.sv */
/* first stage: one holding register, takes a request and emits operand
   magnitudes plus the product sign one cycle later */
`timescale 1ns/1ns
`default_nettype none

`include "imul_config.svh"

module imul_operand_stage (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_val,
  output logic              req_rdy,
  input  imul_pkg::operand_t req_a,
  input  imul_pkg::operand_t req_b,
  imul_mag_if.src           mag
);
  import imul_pkg::*;

  // holding register
  logic     val_q;
  operand_t mag_a_q;
  operand_t mag_b_q;
  logic     neg_q;

  logic     accept;
  logic     sign_a;
  logic     sign_b;

  // operand sign bits
  assign sign_a = req_a[`IMUL_WIDTH-1];
  assign sign_b = req_b[`IMUL_WIDTH-1];

  // open when empty or when the next stage drains us this edge
  assign req_rdy = !val_q || mag.rdy;
  assign accept  = req_val && req_rdy;

  // valid bit
  // a drain with no new request leaves the register empty
  always_ff @(posedge clk) begin
    if (reset) begin
      val_q <= 1'b0;
    end else if (req_rdy) begin
      val_q <= req_val;
    end
  end

  // payload, two's complement magnitude per operand
  // most negative value negates to itself, which is right read as unsigned
  always_ff @(posedge clk) begin
    if (accept) begin
      mag_a_q <= sign_a ? -req_a : req_a;
      mag_b_q <= sign_b ? -req_b : req_b;
      neg_q   <= sign_a ^ sign_b;
    end
  end

  assign mag.val   = val_q;
  assign mag.mag_a = mag_a_q;
  assign mag.mag_b = mag_b_q;
  assign mag.neg   = neg_q;

  // sender must not withdraw a pending transfer
  a_mag_val_held: assert property (@(posedge clk) disable iff (reset)
    (mag.val && !mag.rdy) |=> mag.val);

endmodule

`default_nettype wire

/* verilog/imul_pkg.sv */
/* word types shared by the multiplier stages and the testbench
   widths come from the config header */
`default_nettype none

package imul_pkg;

  `include "imul_config.svh"

  // --------------------------------------------------
  // word types
  // --------------------------------------------------

  // one signed operand or its unsigned magnitude
  typedef logic [`IMUL_WIDTH-1:0] operand_t;

  // one product word, signed result or unsigned magnitude
  typedef logic [`IMUL_PROD_WIDTH-1:0] product_t;

endpackage

`default_nettype wire

/* verilog/imul_sign_stage.sv */
/* third stage: restores the product sign into one output register and
   holds it until resp_rdy is seen */
`timescale 1ns/1ns
`default_nettype none

module imul_sign_stage (
  input  logic               clk,
  input  logic               reset,
  imul_prod_if.dst           prod,
  output logic               resp_val,
  input  logic               resp_rdy,
  output imul_pkg::product_t resp_result
);
  import imul_pkg::*;

  logic     val_q;
  product_t result_q;

  // open when empty or when the consumer takes the result this edge
  assign prod.rdy = !val_q || resp_rdy;

  // valid bit
  always_ff @(posedge clk) begin
    if (reset) begin
      val_q <= 1'b0;
    end else if (prod.rdy) begin
      val_q <= prod.val;
    end
  end

  // two's complement negate for a negative product
  always_ff @(posedge clk) begin
    if (prod.val && prod.rdy) begin
      result_q <= prod.neg ? -prod.mag : prod.mag;
    end
  end

  assign resp_val    = val_q;
  assign resp_result = result_q;

  // response must not change while stalled
  a_resp_stable: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> $stable(resp_result));

endmodule

`default_nettype wire

/* verilog/imul_top.sv */
/* signed IMUL_WIDTH x IMUL_WIDTH multiplier, three val/rdy stages;
   up to three products in flight, results return in request order */
`timescale 1ns/1ns
`default_nettype none

module imul_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               req_val,
  output logic               req_rdy,
  input  imul_pkg::operand_t req_a,
  input  imul_pkg::operand_t req_b,
  output logic               resp_val,
  input  logic               resp_rdy,
  output imul_pkg::product_t resp_result
);

  // stage links
  imul_mag_if  mag_if ();
  imul_prod_if prod_if ();

  // magnitudes and product sign
  imul_operand_stage i_operand_stage (
    .clk     (clk),
    .reset   (reset),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .req_a   (req_a),
    .req_b   (req_b),
    .mag     (mag_if.src)
  );

  // unsigned shift-add core
  imul_iter_stage i_iter_stage (
    .clk   (clk),
    .reset (reset),
    .mag   (mag_if.dst),
    .prod  (prod_if.src)
  );

  // sign restore and response register
  imul_sign_stage i_sign_stage (
    .clk         (clk),
    .reset       (reset),
    .prod        (prod_if.dst),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

endmodule

`default_nettype wire
